/* hdl/udt_pkg.sv */
`default_nettype none

package udt_pkg;

	typedef logic [63:0] data_t;          // One stream data word
	typedef logic [7:0]  keep_t;          // Byte enables
	typedef logic [30:0] seq_t;           // UDT packet sequence number
	typedef logic [31:0] socket_id_t;
	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [15:0] udp_port_t;
	typedef logic [2:0]  ctrl_addr_t;     // Register address

	typedef struct packed {
		data_t data;
		keep_t keep;
		logic  last;
	} axis_beat_t;

	// Same field order as the UDP stack expects
	typedef struct packed {
		mac_addr_t mac_src;
		mac_addr_t mac_dest;
		ip_addr_t  ip_src;
		ip_addr_t  ip_dest;
		udp_port_t port_src;
		udp_port_t port_dest;
	} udp_meta_t;

	typedef struct packed {
		logic       connected;
		ip_addr_t   ip_dest;
		udp_port_t  port_dest;
		seq_t       isn;            // Initial sequence number
		socket_id_t socket_id;
	} ctrl_cfg_t;

	localparam ctrl_addr_t REG_CONNECT   = 3'd0;
	localparam ctrl_addr_t REG_IP_DEST   = 3'd1;
	localparam ctrl_addr_t REG_PORT_DEST = 3'd2;
	localparam ctrl_addr_t REG_ISN       = 3'd3;
	localparam ctrl_addr_t REG_SOCKET_ID = 3'd4;

	typedef enum logic [1:0] {
		PK_IDLE,
		PK_HEADER,
		PK_BODY
	} packer_state_t;

endpackage

`default_nettype wire

/* hdl/udt_ctrl_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module udt_ctrl_regs (
	input  wire logic                  core_clk,
	input  wire logic                  rst,
	input  wire logic                  ctrl_wr,     // One-cycle write strobe
	input  wire udt_pkg::ctrl_addr_t   ctrl_addr,
	input  wire logic [31:0]           ctrl_wdata,
	output udt_pkg::ctrl_cfg_t         cfg
);

	import udt_pkg::*;

	always_ff @(posedge core_clk) begin
		if (rst) begin
			cfg <= '0;                  // Disconnected, all fields cleared
		end else if (ctrl_wr) begin
			case (ctrl_addr)
				REG_CONNECT: begin
					cfg.connected <= ctrl_wdata[0];
				end
				REG_IP_DEST: begin
					cfg.ip_dest <= ctrl_wdata;
				end
				REG_PORT_DEST: begin
					cfg.port_dest <= ctrl_wdata[15:0];      // Upper half dropped
				end
				REG_ISN: begin
					cfg.isn <= ctrl_wdata[30:0];            // Top bit is the packet type
				end
				REG_SOCKET_ID: begin
					cfg.socket_id <= ctrl_wdata;
				end
				default: begin
					cfg <= cfg;                             // Unknown address
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/udt_tx_packer.sv */
`timescale 1ns/100ps
`default_nettype none

module udt_tx_packer (
	input  wire logic                  core_clk,
	input  wire logic                  rst,
	input  wire udt_pkg::ctrl_cfg_t    cfg,
	input  wire logic                  tx_axis_tvalid,
	output logic                       tx_axis_tready,
	input  wire udt_pkg::axis_beat_t   tx_axis_beat,
	output logic                       pk_valid,
	input  wire logic                  pk_ready,
	output udt_pkg::axis_beat_t        pk_beat
);

	import udt_pkg::*;

	packer_state_t state;
	packer_state_t state_next;
	seq_t          seq_num;             // Sequence number of the next packet
	axis_beat_t    hdr_beat;
	logic          slot_free;           // Output register empty or draining
	logic          hdr_load;
	logic          body_load;

	assign slot_free = !pk_valid || pk_ready;
	assign hdr_load  = (state == PK_IDLE) && cfg.connected && tx_axis_tvalid && slot_free;

	// User beats pass only in the body phase
	assign tx_axis_tready = cfg.connected && (state == PK_BODY) && slot_free;
	assign body_load      = tx_axis_tvalid && tx_axis_tready;

	// Data packet header: type bit 0, sequence, socket id
	assign hdr_beat.data = {1'b0, seq_num, cfg.socket_id};
	assign hdr_beat.keep = '1;
	assign hdr_beat.last = 1'b0;

	always_comb begin
		state_next = state;
		case (state)
			PK_IDLE: begin
				if (hdr_load)
					state_next = PK_HEADER;
			end
			PK_HEADER: begin
				if (pk_ready)
					state_next = PK_BODY;   // Header taken by the FIFO
			end
			PK_BODY: begin
				if (body_load && tx_axis_beat.last)
					state_next = PK_IDLE;
			end
			default: begin
				state_next = PK_IDLE;
			end
		endcase
	end

	always_ff @(posedge core_clk) begin
		if (rst) begin
			state    <= PK_IDLE;
			pk_valid <= 1'b0;
			seq_num  <= '0;
		end else begin
			state <= state_next;
			if (hdr_load || body_load)
				pk_valid <= 1'b1;
			else if (pk_ready)
				pk_valid <= 1'b0;
			if (!cfg.connected)
				seq_num <= cfg.isn;         // Track ISN until connected
			else if (hdr_load)
				seq_num <= seq_num + 1'b1;  // Wraps at 31 bits
		end
	end

	always_ff @(posedge core_clk) begin
		if (hdr_load)
			pk_beat <= hdr_beat;
		else if (body_load)
			pk_beat <= tx_axis_beat;
	end

endmodule

`default_nettype wire

/* hdl/udt_beat_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module udt_beat_fifo #(
	parameter int FIFO_DEPTH = 16               // Power of two
) (
	input  wire logic                  core_clk,
	input  wire logic                  rst,
	input  wire logic                  pk_valid,
	output logic                       pk_ready,
	input  wire udt_pkg::axis_beat_t   pk_beat,
	output logic                       ff_valid,
	input  wire logic                  ff_ready,
	output udt_pkg::axis_beat_t        ff_beat
);

	import udt_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	axis_beat_t    mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   fill;                // One bit wider to hold a full count
	logic          wr_en;
	logic          rd_en;

	assign pk_ready = (fill != FIFO_DEPTH[AW:0]);
	assign ff_valid = (fill != '0);
	assign ff_beat  = mem[rd_ptr];      // First word falls through

	assign wr_en = pk_valid && pk_ready;
	assign rd_en = ff_valid && ff_ready;

	always_ff @(posedge core_clk) begin
		if (wr_en)
			mem[wr_ptr] <= pk_beat;
	end

	always_ff @(posedge core_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;      // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/udp_tx_emitter.sv */
`timescale 1ns/100ps
`default_nettype none

module udp_tx_emitter #(
	parameter udt_pkg::mac_addr_t FPGA_MAC_SRC = 48'hba0203040506,
	parameter udt_pkg::mac_addr_t FPGA_MAC_DES = 48'hffffffffffff,
	parameter udt_pkg::ip_addr_t  FPGA_IP_SRC  = 32'hc0a8006f,
	parameter udt_pkg::udp_port_t FPGA_PORT    = 16'd10086
) (
	input  wire logic                  core_clk,
	input  wire logic                  rst,
	input  wire udt_pkg::ctrl_cfg_t    cfg,
	input  wire logic                  ff_valid,
	output logic                       ff_ready,
	input  wire udt_pkg::axis_beat_t   ff_beat,
	output logic                       udp_tx_tvalid,
	input  wire logic                  udp_tx_tready,
	output udt_pkg::axis_beat_t        udp_tx_beat,
	output udt_pkg::udp_meta_t         udp_tx_meta
);

	logic load;
	logic mid_pkt;                      // Cleared after last, so low marks a packet start

	// Slice takes a new beat when empty or emptying
	assign ff_ready = !udp_tx_tvalid || udp_tx_tready;
	assign load     = ff_valid && ff_ready;

	always_ff @(posedge core_clk) begin
		if (rst) begin
			udp_tx_tvalid <= 1'b0;
			mid_pkt       <= 1'b0;
		end else begin
			if (load)
				udp_tx_tvalid <= 1'b1;
			else if (udp_tx_tready)
				udp_tx_tvalid <= 1'b0;
			if (load)
				mid_pkt <= !ff_beat.last;
		end
	end

	always_ff @(posedge core_clk) begin
		if (load)
			udp_tx_beat <= ff_beat;
	end

	// Metadata latched once per packet, held over its beats
	always_ff @(posedge core_clk) begin
		if (load && !mid_pkt) begin
			udp_tx_meta.mac_src   <= FPGA_MAC_SRC;
			udp_tx_meta.mac_dest  <= FPGA_MAC_DES;
			udp_tx_meta.ip_src    <= FPGA_IP_SRC;
			udp_tx_meta.ip_dest   <= cfg.ip_dest;
			udp_tx_meta.port_src  <= FPGA_PORT;
			udp_tx_meta.port_dest <= cfg.port_dest;
		end
	end

endmodule

`default_nettype wire

/* hdl/udt_interface.sv */
`timescale 1ns/100ps
`default_nettype none

module udt_interface #(
	parameter udt_pkg::mac_addr_t FPGA_MAC_SRC = 48'hba0203040506,
	parameter udt_pkg::mac_addr_t FPGA_MAC_DES = 48'hffffffffffff,   // Broadcast
	parameter udt_pkg::ip_addr_t  FPGA_IP_SRC  = 32'hc0a8006f,
	parameter udt_pkg::udp_port_t FPGA_PORT    = 16'd10086,
	parameter int                 FIFO_DEPTH   = 16
) (
	input  wire logic                  core_clk,
	input  wire logic                  rst,
	input  wire logic                  ctrl_wr,
	input  wire udt_pkg::ctrl_addr_t   ctrl_addr,
	input  wire logic [31:0]           ctrl_wdata,
	input  wire logic                  tx_axis_tvalid,
	output logic                       tx_axis_tready,
	input  wire udt_pkg::axis_beat_t   tx_axis_beat,
	output logic                       udp_tx_tvalid,
	input  wire logic                  udp_tx_tready,
	output udt_pkg::axis_beat_t        udp_tx_beat,
	output udt_pkg::udp_meta_t         udp_tx_meta
);

	import udt_pkg::*;

	ctrl_cfg_t  cfg;
	logic       pk_valid;
	logic       pk_ready;
	axis_beat_t pk_beat;
	logic       ff_valid;
	logic       ff_ready;
	axis_beat_t ff_beat;

	udt_ctrl_regs regs_inst (
		.core_clk   (core_clk),
		.rst        (rst),
		.ctrl_wr    (ctrl_wr),
		.ctrl_addr  (ctrl_addr),
		.ctrl_wdata (ctrl_wdata),
		.cfg        (cfg)
	);

	udt_tx_packer packer_inst (
		.core_clk       (core_clk),
		.rst            (rst),
		.cfg            (cfg),
		.tx_axis_tvalid (tx_axis_tvalid),
		.tx_axis_tready (tx_axis_tready),
		.tx_axis_beat   (tx_axis_beat),
		.pk_valid       (pk_valid),
		.pk_ready       (pk_ready),
		.pk_beat        (pk_beat)
	);

	udt_beat_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) fifo_inst (
		.core_clk (core_clk),
		.rst      (rst),
		.pk_valid (pk_valid),
		.pk_ready (pk_ready),
		.pk_beat  (pk_beat),
		.ff_valid (ff_valid),
		.ff_ready (ff_ready),
		.ff_beat  (ff_beat)
	);

	udp_tx_emitter #(
		.FPGA_MAC_SRC (FPGA_MAC_SRC),
		.FPGA_MAC_DES (FPGA_MAC_DES),
		.FPGA_IP_SRC  (FPGA_IP_SRC),
		.FPGA_PORT    (FPGA_PORT)
	) emitter_inst (
		.core_clk      (core_clk),
		.rst           (rst),
		.cfg           (cfg),
		.ff_valid      (ff_valid),
		.ff_ready      (ff_ready),
		.ff_beat       (ff_beat),
		.udp_tx_tvalid (udp_tx_tvalid),
		.udp_tx_tready (udp_tx_tready),
		.udp_tx_beat   (udp_tx_beat),
		.udp_tx_meta   (udp_tx_meta)
	);

endmodule

`default_nettype wire

/* tb/tb_udt_interface.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_udt_interface;

	import udt_pkg::*;

	localparam int        TIMEOUT      = 200;
	localparam mac_addr_t MAC_SRC_DEF  = 48'hba0203040506;
	localparam mac_addr_t MAC_DES_DEF  = 48'hffffffffffff;
	localparam ip_addr_t  IP_SRC_DEF   = 32'hc0a8006f;
	localparam udp_port_t PORT_SRC_DEF = 16'd10086;

	typedef struct packed {
		logic [2:0] len;                // Beats of user data
		ip_addr_t   ip;
		udp_port_t  port;
		seq_t       isn;
		socket_id_t sock;
		logic       reconnect;
	} stim_t;

	typedef struct packed {
		axis_beat_t beat;
		udp_meta_t  meta;
	} exp_t;

	logic        core_clk;
	logic        rst;
	logic        ctrl_wr;
	ctrl_addr_t  ctrl_addr;
	logic [31:0] ctrl_wdata;
	logic        tx_axis_tvalid;
	logic        tx_axis_tready;
	axis_beat_t  tx_axis_beat;
	logic        udp_tx_tvalid;
	logic        udp_tx_tready;
	axis_beat_t  udp_tx_beat;
	udp_meta_t   udp_tx_meta;

	stim_t       stim [6];
	exp_t        exp_q [$];             // Scoreboard of beats still to come out
	seq_t        exp_seq;
	logic [31:0] data_rng = 32'h3ddca814;
	logic [31:0] ready_rng = 32'h3ddca814;
	int          errors = 0;
	int          timeouts = 0;

	udt_interface i_udt_interface (.*);

	initial begin
		core_clk = 1'b0;
		forever #5 core_clk = ~core_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic finish_run();
		$display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	endtask

	task automatic check_quiet();
		assert (udp_tx_tvalid == 1'b0) else begin
			errors++;
			$display("Mismatch udp_tx_tvalid: got %h expected 0", udp_tx_tvalid);
		end
		assert (tx_axis_tready == 1'b0) else begin
			errors++;
			$display("Mismatch tx_axis_tready: got %h expected 0", tx_axis_tready);
		end
	endtask

	task automatic write_reg(input ctrl_addr_t addr, input logic [31:0] data);
		@(negedge core_clk);
		ctrl_wr    = 1'b1;
		ctrl_addr  = addr;
		ctrl_wdata = data;
		@(negedge core_clk);
		ctrl_wr    = 1'b0;
	endtask

	task automatic wait_drain();
		int cnt;
		cnt = 0;
		while (exp_q.size() != 0 && cnt < TIMEOUT) begin
			@(negedge core_clk);
			cnt++;
		end
		if (exp_q.size() != 0) begin
			timeouts++;
			$display("Timeout waiting for output, %0d beats never arrived", exp_q.size());
			finish_run();
		end
	endtask

	task automatic drive_beat(input axis_beat_t b);
		int cnt;
		cnt = 0;
		@(negedge core_clk);
		tx_axis_tvalid = 1'b1;
		tx_axis_beat   = b;
		while (!tx_axis_tready && cnt < TIMEOUT) begin   // Accepted at the next rising edge
			@(negedge core_clk);
			cnt++;
		end
		if (!tx_axis_tready) begin
			timeouts++;
			$display("Timeout waiting for the packer to accept a user beat");
			finish_run();
		end
	endtask

	task automatic send_packet(input stim_t s);
		exp_t       e;
		udp_meta_t  m;
		axis_beat_t b;
		m = '{MAC_SRC_DEF, MAC_DES_DEF, IP_SRC_DEF, s.ip, PORT_SRC_DEF, s.port};
		e.beat.data = {1'b0, exp_seq, s.sock};          // Data packet header
		e.beat.keep = 8'hff;
		e.beat.last = 1'b0;
		e.meta      = m;
		exp_q.push_back(e);
		exp_seq = exp_seq + 31'd1;
		for (int i = 0; i < int'(s.len); i++) begin
			data_rng       = xorshift32(data_rng);
			b.data[63:32]  = data_rng;
			data_rng       = xorshift32(data_rng);
			b.data[31:0]   = data_rng;
			data_rng       = xorshift32(data_rng);
			b.keep         = data_rng[7:0];
			b.last         = (i == int'(s.len) - 1);
			e.beat         = b;
			exp_q.push_back(e);
			drive_beat(b);
		end
		@(negedge core_clk);
		tx_axis_tvalid = 1'b0;
	endtask

	// Beats still in flight must keep the metadata taken with their header
	task automatic rewrite_dest_in_flight(input stim_t s);
		int cnt;
		cnt = 0;
		while (exp_q.size() > int'(s.len) && cnt < TIMEOUT) begin
			@(negedge core_clk);
			cnt++;
		end
		if (exp_q.size() > int'(s.len)) begin
			timeouts++;
			$display("Timeout waiting for the header beat to leave the emitter");
			finish_run();
		end
		write_reg(REG_IP_DEST, ~s.ip);
		write_reg(REG_PORT_DEST, {16'h0000, ~s.port});
	endtask

	task automatic check_output();
		exp_t e;
		assert (exp_q.size() != 0) else begin
			errors++;
			$display("Output beat %h arrived with nothing left to expect", udp_tx_beat);
		end
		if (exp_q.size() != 0) begin
			e = exp_q.pop_front();
			assert (udp_tx_beat == e.beat) else begin
				errors++;
				$display("Mismatch udp_tx_beat: got %h expected %h", udp_tx_beat, e.beat);
			end
			assert (udp_tx_meta == e.meta) else begin
				errors++;
				$display("Mismatch udp_tx_meta: got %h expected %h", udp_tx_meta, e.meta);
			end
		end
	endtask

	// Random back-pressure; a beat counts when valid and ready meet at the next edge
	always @(negedge core_clk) begin
		ready_rng     = xorshift32(ready_rng);
		udp_tx_tready = (ready_rng[1:0] != 2'b00);
		if (!rst && udp_tx_tvalid && udp_tx_tready)
			check_output();
	end

	initial begin
		rst            = 1'b1;
		ctrl_wr        = 1'b0;
		ctrl_addr      = '0;
		ctrl_wdata     = '0;
		tx_axis_tvalid = 1'b0;
		tx_axis_beat   = '0;
		udp_tx_tready  = 1'b0;
		exp_seq        = '0;
		stim[0] = '{3'd1, 32'hc0a80010, 16'd5000, 31'h0000_0010, 32'h0000_1001, 1'b1};
		stim[1] = '{3'd4, 32'hc0a80011, 16'd5001, 31'h0000_0020, 32'h0000_1001, 1'b0};
		stim[2] = '{3'd6, 32'h0a000001, 16'd6000, 31'h7fff_fffe, 32'h0000_2002, 1'b1};
		stim[3] = '{3'd2, 32'h0a000002, 16'd6001, 31'h0000_0000, 32'h0000_2002, 1'b0};
		stim[4] = '{3'd5, 32'h0a000003, 16'd6002, 31'h0000_0000, 32'h0000_3003, 1'b0};
		stim[5] = '{3'd3, 32'hc0a80020, 16'd7000, 31'h1234_5678, 32'h0000_4004, 1'b1};

		for (int i = 0; i < 4; i++) begin
			@(negedge core_clk);
			check_quiet();
		end
		rst = 1'b0;
		@(negedge core_clk);
		check_quiet();

		// Not connected, so the beat must stay stuck at the input
		tx_axis_beat   = '{64'h0123456789abcdef, 8'hff, 1'b1};
		tx_axis_tvalid = 1'b1;
		for (int i = 0; i < 20; i++) begin
			@(negedge core_clk);
			check_quiet();
		end
		tx_axis_tvalid = 1'b0;

		for (int k = 0; k < 6; k++) begin
			wait_drain();
			if (stim[k].reconnect)
				write_reg(REG_CONNECT, 32'd0);
			write_reg(REG_IP_DEST, stim[k].ip);
			write_reg(REG_PORT_DEST, {16'hbeef, stim[k].port});   // Upper half ignored
			write_reg(REG_ISN, {1'b1, stim[k].isn});
			write_reg(REG_SOCKET_ID, stim[k].sock);
			write_reg(3'd7, 32'hffff_ffff);                      // Unmapped address
			if (stim[k].reconnect) begin
				write_reg(REG_CONNECT, 32'd1);
				exp_seq = stim[k].isn;
			end
			send_packet(stim[k]);
			rewrite_dest_in_flight(stim[k]);
		end
		wait_drain();
		repeat (20) @(negedge core_clk);    // Catch late duplicates
		finish_run();
	end

endmodule

`default_nettype wire

/* udt_interface.f */
hdl/udt_pkg.sv
hdl/udt_ctrl_regs.sv
hdl/udt_tx_packer.sv
hdl/udt_beat_fifo.sv
hdl/udp_tx_emitter.sv
hdl/udt_interface.sv
tb/tb_udt_interface.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UDT transmit path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_udt_interface -f udt_interface.f

out=$(./obj_dir/Vtb_udt_interface)
echo "$out"

if echo "$out" | grep -q "^Everything OK$"; then
	exit 0
fi
exit 1
